// ==== vlog.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/fetch_queue.sv
hdl/instr_aligner.sv
hdl/fetch_front_end.sv
bench/fetch_front_end_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

TOP := fetch_front_end_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)

# Status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== bench/fetch_front_end_tb.sv ====
// ========================================
// Fetch front end testbench
// Random program image behind an in-order memory with random latency,
// checked against a reference walk of the instruction stream
// ========================================

`timescale 1ns/1ns
`default_nettype none

module fetch_front_end_tb;

    // Six tests of at most 600 cycles each, with margin on top
    localparam int CYCLE_LIMIT = 4000;

    logic             clk_i = 1'b0;
    logic             rst_n_i;
    logic             exception_i;
    logic             interrupt_i;
    logic             handler_return_i;
    logic             executed_i;
    logic             taken_i;
    logic             jump_i;
    fetch_pkg::addr_t handler_pc_i;
    fetch_pkg::addr_t handler_return_pc_i;
    fetch_pkg::addr_t branch_target_i;
    logic             stall_i;
    logic             mem_valid_i;
    fetch_pkg::word_t mem_data_i;
    logic             fetch_o;
    fetch_pkg::addr_t fetch_addr_o;
    logic             instr_valid_o;
    logic             ready_o;
    logic             compressed_o;
    fetch_pkg::word_t instr_o;
    fetch_pkg::addr_t instr_pc_o;

    // Program image, 256 words that repeat every 1 KiB
    fetch_pkg::word_t image [256];
    logic [15:0]      lfsr_state = 16'd49356;

    // Outstanding memory requests and the edge at which each is answered
    fetch_pkg::addr_t req_addr_q [$];
    int               req_due_q [$];
    fetch_pkg::addr_t resp_addr;
    int               cyc = 0;

    // Reference walker state
    fetch_pkg::addr_t exp_pc = fetch_pkg::RESET_PC;
    fetch_pkg::addr_t exp_fetch_addr = fetch_pkg::RESET_PC;
    fetch_pkg::addr_t redirect_pc;
    logic             redirect_now;
    logic             after_redirect = 1'b0;
    logic             held = 1'b0;
    fetch_pkg::word_t held_instr;
    fetch_pkg::addr_t held_pc;
    logic             held_compressed;

    int test_checks = 0;
    int test_errors = 0;
    int test_delivered = 0;
    int total_checks = 0;
    int total_errors = 0;
    int tests_run = 0;

    fetch_front_end fetch_front_end_i (.*);

    always #4 clk_i = ~clk_i;

    // ========================================
    // Random numbers and the program image
    // ========================================

    // Galois LFSR, one step for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Half-word aligned target anywhere in the first 4 KiB
    function automatic fetch_pkg::addr_t random_target(input logic upper);
        fetch_pkg::addr_t t;
        t    = rand_bits(10) << 2;
        t[1] = upper;
        return t;
    endfunction

    function automatic fetch_pkg::half_t half_at(input fetch_pkg::addr_t a);
        fetch_pkg::word_t w;
        w = image[a[9:2]];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_word(input string what, input fetch_pkg::word_t got,
                              input fetch_pkg::word_t exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // A parcel ending in 11 opens a 32 bit instruction, anything else is compressed
    task automatic walk_and_check();
        fetch_pkg::half_t parcel;
        fetch_pkg::word_t exp_instr;
        logic             exp_compressed;
        parcel         = half_at(exp_pc);
        exp_compressed = (parcel[1:0] != 2'b11);
        if (exp_compressed) begin
            exp_instr = {16'h0000, parcel};
        end else begin
            exp_instr = {half_at(exp_pc + 32'd2), parcel};
        end
        check_word("instr_o", instr_o, exp_instr);
        check_addr("instr_pc_o", instr_pc_o, exp_pc);
        check_bit("compressed_o", compressed_o, exp_compressed);
        exp_pc = exp_pc + (exp_compressed ? 32'd2 : 32'd4);
        test_delivered++;
    endtask

    // ========================================
    // Memory model, observer and cycle limit
    // ========================================

    // Oldest request is answered once its latency has run out
    always @(posedge clk_i) begin
        #1;
        mem_valid_i = 1'b0;
        if (req_addr_q.size() != 0 && req_due_q[0] <= cyc + 1) begin
            resp_addr = req_addr_q.pop_front();
            req_due_q.delete(0);
            mem_valid_i = 1'b1;
            mem_data_i  = image[resp_addr[9:2]];
        end
    end

    // Everything is sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            redirect_now = exception_i | interrupt_i | handler_return_i
                         | (executed_i & (taken_i | jump_i));
            if (exception_i | interrupt_i) begin
                redirect_pc = handler_pc_i;
            end else if (handler_return_i) begin
                redirect_pc = handler_return_pc_i;
            end else begin
                redirect_pc = branch_target_i;
            end
            // A redirect fetches the word that holds the winning target
            if (redirect_now) begin
                check_bit("fetch_o on redirect", fetch_o, 1'b1);
                exp_fetch_addr = {redirect_pc[31:2], 2'b00};
            end
            // Latency of one to three cycles after the request edge
            if (fetch_o) begin
                check_addr("fetch_addr_o", fetch_addr_o, exp_fetch_addr);
                exp_fetch_addr = exp_fetch_addr + 32'd4;
                req_addr_q.push_back(fetch_addr_o);
                req_due_q.push_back(cyc + 2 + int'(rand_bits(2) % 3));
            end
            check_bit("ready_o", ready_o, instr_valid_o & ~stall_i);
            if (after_redirect) begin
                check_bit("instr_valid_o after redirect", instr_valid_o, 1'b0);
            end
            if (held) begin
                check_bit("instr_valid_o under stall", instr_valid_o, 1'b1);
                check_word("instr_o under stall", instr_o, held_instr);
                check_addr("instr_pc_o under stall", instr_pc_o, held_pc);
                check_bit("compressed_o under stall", compressed_o, held_compressed);
            end
            // The instruction shown in a redirect cycle still belongs to the old path
            if (instr_valid_o && ready_o) begin
                walk_and_check();
            end
            held            = instr_valid_o & stall_i & ~redirect_now;
            held_instr      = instr_o;
            held_pc         = instr_pc_o;
            held_compressed = compressed_o;
            after_redirect  = redirect_now;
            if (redirect_now) begin
                exp_pc = redirect_pc;
            end
        end
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles before the tests finished", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Roughly one cycle in four is stalled
    task automatic run_stalled(input int n);
        repeat (n) begin
            stall_i = (rand_bits(2) == 0);
            next_cycle();
        end
        stall_i = 1'b0;
    endtask

    // Strobes set by the caller last for exactly one cycle
    task automatic pulse_strobes();
        next_cycle();
        exception_i      = 1'b0;
        interrupt_i      = 1'b0;
        handler_return_i = 1'b0;
        executed_i       = 1'b0;
        taken_i          = 1'b0;
        jump_i           = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (test_delivered == 0) begin
            test_errors++;
            $display("Test %s delivered no instruction at all", name);
        end
        $display("Test %s: %0d instructions, %0d checks, %0d errors",
                 name, test_delivered, test_checks, test_errors);
        tests_run++;
        total_checks   += test_checks;
        total_errors   += test_errors;
        test_checks    = 0;
        test_errors    = 0;
        test_delivered = 0;
    endtask

    initial begin
        int k;
        rst_n_i             = 1'b0;
        exception_i         = 1'b0;
        interrupt_i         = 1'b0;
        handler_return_i    = 1'b0;
        executed_i          = 1'b0;
        taken_i             = 1'b0;
        jump_i              = 1'b0;
        handler_pc_i        = '0;
        handler_return_pc_i = '0;
        branch_target_i     = '0;
        stall_i             = 1'b0;
        mem_valid_i         = 1'b0;
        mem_data_i          = '0;
        for (k = 0; k < 256; k++) begin
            image[k] = rand_bits(32);
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        run_cycles(200);
        end_test("reset_stream");

        // Alternate lower and upper half targets
        for (k = 0; k < 8; k++) begin
            executed_i      = 1'b1;
            taken_i         = (rand_bits(1) != 0);
            jump_i          = ~taken_i;
            branch_target_i = random_target(k[0]);
            pulse_strobes();
            run_cycles(30);
        end
        end_test("branch_jump");

        handler_pc_i        = random_target(1'b0);
        handler_return_pc_i = random_target(1'b1);
        branch_target_i     = random_target(1'b0);
        exception_i         = 1'b1;
        handler_return_i    = 1'b1;
        executed_i          = 1'b1;
        taken_i             = 1'b1;
        pulse_strobes();
        run_cycles(40);
        handler_pc_i    = random_target(1'b1);
        branch_target_i = random_target(1'b0);
        interrupt_i     = 1'b1;
        executed_i      = 1'b1;
        jump_i          = 1'b1;
        pulse_strobes();
        run_cycles(40);
        handler_return_pc_i = random_target(1'b0);
        branch_target_i     = random_target(1'b1);
        handler_return_i    = 1'b1;
        executed_i          = 1'b1;
        taken_i             = 1'b1;
        pulse_strobes();
        run_cycles(40);
        end_test("priority");

        // Target is present but must be ignored
        for (k = 0; k < 5; k++) begin
            executed_i      = 1'b1;
            branch_target_i = random_target(1'b1);
            pulse_strobes();
            run_cycles(20);
        end
        end_test("not_taken");

        run_stalled(400);
        end_test("random_stall");

        // Redirects that may land while the back end is stalled
        for (k = 0; k < 8; k++) begin
            run_stalled(30);
            stall_i         = (rand_bits(1) != 0);
            executed_i      = 1'b1;
            jump_i          = 1'b1;
            branch_target_i = random_target(rand_bits(1) != 0);
            pulse_strobes();
        end
        stall_i = 1'b0;
        run_cycles(20);
        end_test("stall_redirect");

        $display("Tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : fetch_front_end_tb

`default_nettype wire

// ==== hdl/fetch_front_end.sv ====
// ======================================
// Fetch front end top level
// Joins PC generation, the fetch queue and the realigner
// ======================================

`timescale 1ns/1ns
`default_nettype none

module fetch_front_end (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             exception_i,
    input  logic             interrupt_i,
    input  logic             handler_return_i,
    input  logic             executed_i,
    input  logic             taken_i,
    input  logic             jump_i,
    input  fetch_pkg::addr_t handler_pc_i,
    input  fetch_pkg::addr_t handler_return_pc_i,
    input  fetch_pkg::addr_t branch_target_i,
    input  logic             stall_i,
    input  logic             mem_valid_i,
    input  fetch_pkg::word_t mem_data_i,
    output logic             fetch_o,
    output fetch_pkg::addr_t fetch_addr_o,
    output logic             instr_valid_o,
    output logic             ready_o,
    output logic             compressed_o,
    output fetch_pkg::word_t instr_o,
    output fetch_pkg::addr_t instr_pc_o
);

    logic             redirect;
    logic             queue_full;
    logic             head_valid;
    logic             pop;
    fetch_pkg::addr_t request_pc;
    fetch_pkg::word_t head_word;
    fetch_pkg::addr_t head_pc;

    pc_gen pc_gen_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .exception_i         (exception_i),
        .interrupt_i         (interrupt_i),
        .handler_return_i    (handler_return_i),
        .executed_i          (executed_i),
        .taken_i             (taken_i),
        .jump_i              (jump_i),
        .handler_pc_i        (handler_pc_i),
        .handler_return_pc_i (handler_return_pc_i),
        .branch_target_i     (branch_target_i),
        .queue_full_i        (queue_full),
        .fetch_o             (fetch_o),
        .redirect_o          (redirect),
        .fetch_addr_o        (fetch_addr_o),
        .request_pc_o        (request_pc)
    );

    // Every request reserves a queue slot in the same cycle
    fetch_queue fetch_queue_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_i      (fetch_o),
        .redirect_i   (redirect),
        .request_pc_i (request_pc),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .pop_i        (pop),
        .full_o       (queue_full),
        .head_valid_o (head_valid),
        .head_word_o  (head_word),
        .head_pc_o    (head_pc)
    );

    instr_aligner instr_aligner_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .stall_i       (stall_i),
        .head_valid_i  (head_valid),
        .head_word_i   (head_word),
        .head_pc_i     (head_pc),
        .pop_o         (pop),
        .instr_valid_o (instr_valid_o),
        .ready_o       (ready_o),
        .compressed_o  (compressed_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o)
    );

endmodule : fetch_front_end

`default_nettype wire

// ==== hdl/instr_aligner.sv ====
// ======================================
// Instruction realigner
// Cuts queue words into 16 bit compressed and 32 bit full instructions,
// joins full instructions that cross a word boundary and registers one
// instruction per cycle with its address
// ======================================

`timescale 1ns/1ns
`default_nettype none

module instr_aligner (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             redirect_i,
    input  logic             stall_i,
    input  logic             head_valid_i,
    input  fetch_pkg::word_t head_word_i,
    input  fetch_pkg::addr_t head_pc_i,
    output logic             pop_o,
    output logic             instr_valid_o,
    output logic             ready_o,
    output logic             compressed_o,
    output fetch_pkg::word_t instr_o,
    output fetch_pkg::addr_t instr_pc_o
);

    fetch_pkg::align_state_t state_q;
    fetch_pkg::align_state_t state_n;
    fetch_pkg::half_t        saved_half_q;
    fetch_pkg::addr_t        saved_pc_q;
    fetch_pkg::half_t        low_half;
    fetch_pkg::half_t        high_half;
    fetch_pkg::word_t        instr_n;
    fetch_pkg::addr_t        instr_pc_n;
    logic                    compressed_n;
    logic                    take_high;
    logic                    advance;
    logic                    done;
    logic                    save_high;

    assign low_half  = head_word_i[15:0];
    assign high_half = head_word_i[31:16];

    // Nothing moves while stalled or while the stream is being redirected
    assign advance = head_valid_i & ~stall_i & ~redirect_i;

    // A target in the upper half skips the low parcel of its first word
    assign take_high = (state_q == fetch_pkg::ALIGN_HIGH)
                     | ((state_q == fetch_pkg::ALIGN_LOW) & head_pc_i[1]);

    // ======================================
    // Parcel selection
    // ======================================

    always_comb begin
        state_n      = state_q;
        done         = 1'b0;
        pop_o        = 1'b0;
        save_high    = 1'b0;
        compressed_n = 1'b0;
        instr_n      = head_word_i;
        instr_pc_n   = {head_pc_i[31:2], 2'b00};

        if (state_q == fetch_pkg::ALIGN_CROSS) begin
            // Low half of the head completes the saved upper half
            instr_n    = {low_half, saved_half_q};
            instr_pc_n = saved_pc_q;
            done       = advance;
            if (advance) begin
                state_n = fetch_pkg::ALIGN_HIGH;
            end
        end else if (take_high) begin
            instr_n      = {16'h0000, high_half};
            instr_pc_n   = {head_pc_i[31:2], 2'b10};
            compressed_n = (high_half[1:0] != 2'b11);
            // The head word is used up in both cases
            pop_o        = advance;
            if (advance) begin
                if (compressed_n) begin
                    done    = 1'b1;
                    state_n = fetch_pkg::ALIGN_LOW;
                end else begin
                    save_high = 1'b1;
                    state_n   = fetch_pkg::ALIGN_CROSS;
                end
            end
        end else begin
            compressed_n = (low_half[1:0] != 2'b11);
            done         = advance;
            if (compressed_n) begin
                instr_n = {16'h0000, low_half};
                if (advance) begin
                    state_n = fetch_pkg::ALIGN_HIGH;
                end
            end else begin
                // Full aligned instruction takes the whole word
                pop_o = advance;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= fetch_pkg::ALIGN_LOW;
        end else if (redirect_i) begin
            state_q <= fetch_pkg::ALIGN_LOW;
        end else begin
            state_q <= state_n;
        end
    end

    // Start of a full instruction that continues in the next word
    always_ff @(posedge clk_i) begin
        if (save_high) begin
            saved_half_q <= high_half;
            saved_pc_q   <= {head_pc_i[31:2], 2'b10};
        end
    end

    // ======================================
    // Output stage
    // ======================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_valid_o <= 1'b0;
        end else if (redirect_i) begin
            instr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            instr_valid_o <= done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done) begin
            instr_o      <= instr_n;
            instr_pc_o   <= instr_pc_n;
            compressed_o <= compressed_n;
        end
    end

    assign ready_o = instr_valid_o & ~stall_i;

    // The word that completes a split instruction directly follows the saved half
    a_cross_in_order : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        head_valid_i && (state_q == fetch_pkg::ALIGN_CROSS) |->
            head_pc_i == saved_pc_q + 32'd2
    );

endmodule : instr_aligner

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
// ======================================
// Fetch queue
// Circular buffer that reserves a slot per request, pairs it with the
// in-order memory response and drops responses that belong to requests
// issued before a redirect
// ======================================

`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             fetch_i,
    input  logic             redirect_i,
    input  fetch_pkg::addr_t request_pc_i,
    input  logic             mem_valid_i,
    input  fetch_pkg::word_t mem_data_i,
    input  logic             pop_i,
    output logic             full_o,
    output logic             head_valid_o,
    output fetch_pkg::word_t head_word_o,
    output fetch_pkg::addr_t head_pc_o
);

    // Slot storage, written by the request and by the response
    fetch_pkg::addr_t pc_mem   [fetch_pkg::FETCH_QUEUE_DEPTH];
    fetch_pkg::word_t word_mem [fetch_pkg::FETCH_QUEUE_DEPTH];

    logic [fetch_pkg::FETCH_QUEUE_DEPTH-1:0]         filled_q;
    logic [$clog2(fetch_pkg::FETCH_QUEUE_DEPTH)-1:0] head_ptr_q;
    logic [$clog2(fetch_pkg::FETCH_QUEUE_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(fetch_pkg::FETCH_QUEUE_DEPTH)-1:0] fill_ptr_q;

    // Reserved slots, live requests not yet answered, stale answers to skip
    fetch_pkg::qcount_t count_q;
    fetch_pkg::qcount_t pending_q;
    fetch_pkg::qcount_t drop_q;

    logic accept;

    // A response is kept only when no stale answers are still due
    assign accept = mem_valid_i & (drop_q == '0) & ~redirect_i;

    assign full_o       = (count_q == fetch_pkg::qcount_t'(fetch_pkg::FETCH_QUEUE_DEPTH));
    assign head_valid_o = filled_q[head_ptr_q];
    assign head_word_o  = word_mem[head_ptr_q];
    assign head_pc_o    = pc_mem[head_ptr_q];

    always_ff @(posedge clk_i) begin
        if (fetch_i) begin
            pc_mem[wr_ptr_q] <= request_pc_i;
        end
        if (accept) begin
            word_mem[fill_ptr_q] <= mem_data_i;
        end
    end

    // ======================================
    // Pointers and counters
    // ======================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_ptr_q <= '0;
            wr_ptr_q   <= '0;
            fill_ptr_q <= '0;
            filled_q   <= '0;
            count_q    <= '0;
            pending_q  <= '0;
            drop_q     <= '0;
        end else begin
            if (fetch_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (redirect_i) begin
                // Empty the queue at the write pointer, the request of this
                // cycle goes into that slot and is the only live one
                head_ptr_q <= wr_ptr_q;
                fill_ptr_q <= wr_ptr_q;
                filled_q   <= '0;
                count_q    <= fetch_pkg::qcount_t'(fetch_i);
                pending_q  <= fetch_pkg::qcount_t'(fetch_i);
                // Every older request still unanswered turns stale
                drop_q <= pending_q + drop_q - fetch_pkg::qcount_t'(mem_valid_i);
            end else begin
                if (accept) begin
                    filled_q[fill_ptr_q] <= 1'b1;
                    fill_ptr_q           <= fill_ptr_q + 1'b1;
                end
                if (pop_i) begin
                    filled_q[head_ptr_q] <= 1'b0;
                    head_ptr_q           <= head_ptr_q + 1'b1;
                end
                if (mem_valid_i && (drop_q != '0)) begin
                    drop_q <= drop_q - 1'b1;
                end
                count_q   <= count_q + fetch_pkg::qcount_t'(fetch_i)
                           - fetch_pkg::qcount_t'(pop_i);
                pending_q <= pending_q + fetch_pkg::qcount_t'(fetch_i)
                           - fetch_pkg::qcount_t'(accept);
            end
        end
    end

    // The PC generator must respect full outside a redirect
    a_no_fetch_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fetch_i && !redirect_i |-> !full_o
    );

    // The realigner only consumes a filled head
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> head_valid_o
    );

    // Memory answers each request once, never unprompted
    a_no_spurious_resp : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_i |-> (pending_q != '0) || (drop_q != '0)
    );

endmodule : fetch_queue

`default_nettype wire

// ==== hdl/pc_gen.sv ====
// ======================================
// Program counter generation
// Holds the PC of the last request and selects the next fetch address.
// Priority is exception or interrupt, then handler return, then an
// executed taken branch or jump, then the next sequential word
// ======================================

`timescale 1ns/1ns
`default_nettype none

module pc_gen (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             exception_i,
    input  logic             interrupt_i,
    input  logic             handler_return_i,
    input  logic             executed_i,
    input  logic             taken_i,
    input  logic             jump_i,
    input  fetch_pkg::addr_t handler_pc_i,
    input  fetch_pkg::addr_t handler_return_pc_i,
    input  fetch_pkg::addr_t branch_target_i,
    input  logic             queue_full_i,
    output logic             fetch_o,
    output logic             redirect_o,
    output fetch_pkg::addr_t fetch_addr_o,
    output fetch_pkg::addr_t request_pc_o
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t seq_pc;
    fetch_pkg::addr_t target_pc;

    // Word that follows the last request, bit 1 of a target is dropped here
    assign seq_pc = {pc_q[31:2], 2'b00} + 32'd4;

    // A not-taken branch that executes leaves the sequential stream alone
    assign redirect_o = exception_i | interrupt_i | handler_return_i
                      | (executed_i & (taken_i | jump_i));

    always_comb begin
        if (exception_i | interrupt_i) begin
            // Trap entry beats everything else
            target_pc = handler_pc_i;
        end else if (handler_return_i) begin
            target_pc = handler_return_pc_i;
        end else begin
            target_pc = branch_target_i;
        end
    end

    // The request PC keeps bit 1 so the realigner knows where to start
    assign request_pc_o = redirect_o ? target_pc : seq_pc;

    // A redirect always fetches since the queue frees its slots in that cycle
    assign fetch_o = redirect_o | ~queue_full_i;

    // Memory is addressed by whole words only
    assign fetch_addr_o = {request_pc_o[31:2], 2'b00};

    // Starts one word below the reset address so the first sequential
    // request after reset lands on RESET_PC
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::RESET_PC - 32'd4;
        end else if (fetch_o) begin
            pc_q <= request_pc_o;
        end
    end

    // Targets supplied by the back end must be half-word aligned
    a_target_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        redirect_o |-> !target_pc[0]
    );

endmodule : pc_gen

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
// ======================================
// Fetch front end package
// Shared widths, queue sizing, the reset address and the states of the
// instruction realigner
// ======================================

`default_nettype none

package fetch_pkg;

    // ======================================
    // Data widths
    // ======================================

    // Byte address of an instruction or of a memory word
    typedef logic [31:0] addr_t;

    // Memory word, also the container of a delivered instruction
    typedef logic [31:0] word_t;

    // One 16 bit parcel of the instruction stream
    typedef logic [15:0] half_t;

    // ======================================
    // Queue sizing and reset
    // ======================================

    // Words that may be outstanding at the memory or waiting in the queue
    localparam int FETCH_QUEUE_DEPTH = 4;

    // Occupancy or drop count, holds 0 up to FETCH_QUEUE_DEPTH
    typedef logic [2:0] qcount_t;

    // First fetch address after reset
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Where the realigner expects the next instruction to begin
    typedef enum logic [1:0] {
        ALIGN_LOW,
        ALIGN_HIGH,
        // Saved upper half waits for the low half of the next word
        ALIGN_CROSS
    } align_state_t;

endpackage : fetch_pkg

`default_nettype wire
